/* sim.f */
+incdir+hw
hw/video_timing_pkg.sv
hw/video_gfx_pkg.sv
hw/video_timer.sv
hw/tile_layer.sv
hw/color_mix.sv
hw/video_top.sv
dv/video_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= video_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hw/*.sv hw/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/video_tb.sv */
// Assumes the ROM answers within 4 clk and that scroll and palette changes are made in vblank
`timescale 1ns/1ps
`include "video_consts.svh"

module video_tb;

    localparam int TIMEOUT_CYCLES = 60000;
    localparam int CHECK_FRAMES   = 4;

    logic                      clk;
    logic                      arst_n;
    logic                      pxl_cen;
    video_gfx_pkg::cpu_bus_t   cpu;
    video_gfx_pkg::pal_addr_t  prog_addr;
    video_gfx_pkg::rgb_t       prog_data;
    logic                      prog_en;
    logic                      pal_sel;
    logic                      rom_valid;
    video_gfx_pkg::rom_addr_t  rom_addr;
    logic                      rom_ready;
    video_gfx_pkg::rom_row_t   rom_data;
    logic                      rom_ok;
    logic                      hs;
    logic                      vs;
    logic                      lhbl_dly;
    logic                      lvbl_dly;
    video_gfx_pkg::rgb_t       rgb;

    // Models of the graphics ROM, map RAM, scroll registers and palette
    logic [31:0]               rom_mem [0:2047];
    logic [7:0]                shadow_map [0:127];
    video_gfx_pkg::rgb_t       shadow_pal [0:31];
    int                        shadow_sx;
    int                        shadow_sy;

    logic [31:0] rng;
    // Separate stream for ROM stalls and latency
    logic [31:0] rom_rng;
    int          errors;
    int          cycles;
    int          checked_pix;
    logic        stall_en;
    logic        armed;

    // ROM model state
    logic        pending;
    int          lat_cnt;
    int          stall_cnt;
    logic [10:0] resp_addr;

    // Checker state
    logic lh_q;
    logic lv_q;
    logic line_seen;
    logic frame_seen;
    logic frame_chk;
    int   x;
    int   y;
    int   line_pix;
    int   act_pix;
    int   hs_pix;
    int   lines;
    int   act_lines;
    int   vs_lines;
    int   f_sx;
    int   f_sy;
    logic f_sel;

    video_top video_top_i (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_en   ( prog_en   ),
        .pal_sel   ( pal_sel   ),
        .rom_valid ( rom_valid ),
        .rom_addr  ( rom_addr  ),
        .rom_ready ( rom_ready ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .rgb       ( rgb       )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Expected colour from the rendering rule
    function automatic video_gfx_pkg::rgb_t ref_rgb(input int px, input int py, input int sx,
                                                    input int sy, input logic sel);
        int          ry;
        int          col;
        int          row;
        int          code;
        int          p;
        logic [31:0] word;
        ry   = (py + sy) % 64;
        col  = ((sx + px) / 8) % 16;
        row  = ry / 8;
        code = int'(shadow_map[7'(row * 16 + col)]);
        word = rom_mem[11'(code * 8 + ry % 8)];
        p    = int'((word >> (4 * ((sx + px) % 8))) & 32'hf);
        return shadow_pal[{sel, p[3:0]}];
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel enable on every second clk
    always @(negedge clk) begin
        if (!arst_n) begin
            pxl_cen = 1'b0;
        end else begin
            pxl_cen = ~pxl_cen;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d clk cycles, frames did not complete", cycles);
            $display("Run ended with %0d errors", errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ROM model deciding acceptance on the falling edge before the DUT sees it
    always @(negedge clk) begin
        logic [31:0] r;
        rom_rng = xorshift32(rom_rng);
        r       = rom_rng;
        rom_ok  = 1'b0;
        if (pending) begin
            if (lat_cnt <= 1) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[resp_addr];
                pending  = 1'b0;
            end else begin
                lat_cnt = lat_cnt - 1;
            end
        end
        if (stall_en && stall_cnt < 3 && r[1:0] == 2'b00) begin
            rom_ready = 1'b0;
            stall_cnt = stall_cnt + 1;
        end else begin
            rom_ready = arst_n;
            stall_cnt = 0;
        end
        if (rom_valid && rom_ready && !pending) begin
            pending   = 1'b1;
            resp_addr = rom_addr;
            lat_cnt   = stall_en ? 1 + int'(r[3:2]) : 1;
        end
    end

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic check_reset_state();
        compare_bit("rom_valid", rom_valid, 1'b0);
        compare_bit("hs", hs, 1'b0);
        compare_bit("vs", vs, 1'b0);
        compare_bit("lhbl_dly", lhbl_dly, 1'b0);
        compare_bit("lvbl_dly", lvbl_dly, 1'b0);
        if (rgb !== 12'h000) begin
            $display("** Error at %0t: rgb expected 000 got %h", $time, rgb);
            errors = errors + 1;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    // One output sample per pixel, taken at the falling edge after pxl_cen
    task automatic sample_outputs();
        video_gfx_pkg::rgb_t exp;
        if (lhbl_dly && !lh_q) begin
            if (line_seen) begin
                compare_count("line length", line_pix, `H_TOTAL);
                compare_count("lhbl_dly active pixels", act_pix, `H_VISIBLE);
                compare_count("hs pixels", hs_pix, `H_SYNC_END - `H_SYNC_START);
            end
            line_seen = 1'b1;
            line_pix  = 0;
            act_pix   = 0;
            hs_pix    = 0;
            x         = 0;
            if (lvbl_dly && !lv_q) begin
                if (frame_seen) begin
                    compare_count("frame lines", lines, `V_TOTAL);
                    compare_count("lvbl_dly active lines", act_lines, `V_VISIBLE);
                    compare_count("vs lines", vs_lines, `V_SYNC_END - `V_SYNC_START);
                end
                frame_seen = 1'b1;
                lines      = 0;
                act_lines  = 0;
                vs_lines   = 0;
                y          = 0;
                frame_chk  = armed;
                f_sx       = shadow_sx;
                f_sy       = shadow_sy;
                f_sel      = pal_sel;
            end else begin
                y = y + 1;
            end
            lines = lines + 1;
            if (lvbl_dly) begin
                act_lines = act_lines + 1;
            end
            if (vs) begin
                vs_lines = vs_lines + 1;
            end
        end else begin
            x = x + 1;
        end
        line_pix = line_pix + 1;
        if (lhbl_dly) begin
            act_pix = act_pix + 1;
        end
        if (hs) begin
            hs_pix = hs_pix + 1;
        end
        if (lhbl_dly && lvbl_dly) begin
            if (frame_chk) begin
                exp = ref_rgb(x, y, f_sx, f_sy, f_sel);
                checked_pix = checked_pix + 1;
                if (rgb !== exp) begin
                    $display("** Error at %0t: rgb at x=%0d y=%0d expected %h got %h",
                             $time, x, y, exp, rgb);
                    errors = errors + 1;
                end
            end
        end else if (rgb !== 12'h000) begin
            $display("** Error at %0t: rgb in blanking expected 000 got %h", $time, rgb);
            errors = errors + 1;
        end
        lh_q = lhbl_dly;
        lv_q = lvbl_dly;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (arst_n && pxl_cen) begin
                @(negedge clk);
                sample_outputs();
            end
        end
    end

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu = '{addr: addr, data: data, we: 1'b1};
        @(negedge clk);
        cpu.we = 1'b0;
    endtask

    task automatic load_palette();
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            shadow_pal[i] = r[11:0];
            @(negedge clk);
            prog_addr = 5'(i);
            prog_data = r[11:0];
            prog_en   = 1'b1;
        end
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    task automatic write_map();
        logic [31:0] r;
        for (int i = 0; i < 128; i++) begin
            r = next_rand();
            shadow_map[i] = r[7:0];
            cpu_write(8'(i), r[7:0]);
        end
    endtask

    task automatic write_scroll(input logic [7:0] sxv, input logic [7:0] syv);
        cpu_write(8'(`SCROLL_X_ADDR), sxv);
        cpu_write(8'(`SCROLL_Y_ADDR), syv);
        shadow_sx = int'(sxv[6:0]);
        shadow_sy = int'(syv[5:0]);
    endtask

    // Checks the frame that follows the current vblank, returns in the next vblank
    task automatic run_checked_frame();
        armed = 1'b1;
        @(posedge lvbl_dly);
        @(negedge lvbl_dly);
        armed = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        rng = 32'd24780;
        rom_rng = 32'd24780;
        errors = 0;
        cycles = 0;
        checked_pix = 0;
        arst_n = 1'b0;
        pxl_cen = 1'b0;
        cpu = '0;
        prog_addr = '0;
        prog_data = '0;
        prog_en = 1'b0;
        pal_sel = 1'b0;
        rom_ready = 1'b0;
        rom_data = '0;
        rom_ok = 1'b0;
        stall_en = 1'b0;
        armed = 1'b0;
        pending = 1'b0;
        lat_cnt = 0;
        stall_cnt = 0;
        resp_addr = '0;
        lh_q = 1'b0;
        lv_q = 1'b0;
        line_seen = 1'b0;
        frame_seen = 1'b0;
        frame_chk = 1'b0;
        x = 0;
        y = 0;
        shadow_sx = 0;
        shadow_sy = 0;
        for (int i = 0; i < 2048; i++) begin
            rom_mem[i] = next_rand();
        end

        repeat (3) begin
            @(negedge clk);
            check_reset_state();
        end
        arst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();

        // Static frame
        load_palette();
        write_map();
        write_scroll(8'h00, 8'h00);
        @(negedge lvbl_dly);
        run_checked_frame();

        // Scroll that wraps across map column 15/0 and row 7/0
        write_scroll(8'h7b, 8'h3a);
        run_checked_frame();

        // Other palette bank
        @(negedge clk);
        pal_sel = 1'b1;
        load_palette();
        run_checked_frame();

        // ROM stalls and variable latency
        stall_en = 1'b1;
        r = next_rand();
        write_scroll(r[7:0], r[15:8]);
        run_checked_frame();
        stall_en = 1'b0;

        if (checked_pix != CHECK_FRAMES * `H_VISIBLE * `V_VISIBLE) begin
            $display("Only %0d active pixels were checked, frames were missed", checked_pix);
            errors = errors + 1;
        end
        $display("Run ended with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* hw/video_top.sv */
// Single clock design, all stages advance on pxl_cen; ROM answers must come within 8 clk of acceptance
`timescale 1ns/1ps

module video_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       pxl_cen,
    // CPU write port
    input  video_gfx_pkg::cpu_bus_t    cpu,
    // Palette download
    input  video_gfx_pkg::pal_addr_t   prog_addr,
    input  video_gfx_pkg::rgb_t        prog_data,
    input  logic                       prog_en,
    input  logic                       pal_sel,
    // Graphics ROM
    output logic                       rom_valid,
    output video_gfx_pkg::rom_addr_t   rom_addr,
    input  logic                       rom_ready,
    input  video_gfx_pkg::rom_row_t    rom_data,
    input  logic                       rom_ok,
    // Video out
    output logic                       hs,
    output logic                       vs,
    output logic                       lhbl_dly,
    output logic                       lvbl_dly,
    output video_gfx_pkg::rgb_t        rgb
);

    video_timing_pkg::raster_t raster;
    video_gfx_pkg::pixel_t     pxl;

    video_timer video_timer_i (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .pxl_cen ( pxl_cen ),
        .raster  ( raster  )
    );

    tile_layer tile_layer_i (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .raster    ( raster    ),
        .rom_valid ( rom_valid ),
        .rom_addr  ( rom_addr  ),
        .rom_ready ( rom_ready ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( pxl       )
    );

    color_mix color_mix_i (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .raster    ( raster    ),
        .pxl       ( pxl       ),
        .pal_sel   ( pal_sel   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_en   ( prog_en   ),
        .rgb       ( rgb       ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

endmodule

/* hw/color_mix.sv */
// Palette has no reset and must be loaded before use; outputs trail the timer raster by two pxl_cen
`timescale 1ns/1ps

module color_mix (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       pxl_cen,
    input  video_timing_pkg::raster_t  raster,
    input  video_gfx_pkg::pixel_t      pxl,
    input  logic                       pal_sel,
    input  video_gfx_pkg::pal_addr_t   prog_addr,
    input  video_gfx_pkg::rgb_t        prog_data,
    input  logic                       prog_en,
    output video_gfx_pkg::rgb_t        rgb,
    output logic                       hs,
    output logic                       vs,
    output logic                       lhbl_dly,
    output logic                       lvbl_dly
);

    localparam int PAL_SIZE = 1 << $bits(video_gfx_pkg::pal_addr_t);

    video_gfx_pkg::rgb_t      pal_mem [0:PAL_SIZE-1];
    video_gfx_pkg::pal_addr_t pal_addr;

    // Flags of the pixel now held in pxl
    logic lhbl_d;
    logic lvbl_d;
    logic hs_d;
    logic vs_d;

    assign pal_addr = {pal_sel, pxl};

    // Download port
    always_ff @(posedge clk) begin
        if (prog_en) begin
            pal_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_d   <= 1'b0;
            lvbl_d   <= 1'b0;
            hs_d     <= 1'b0;
            vs_d     <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d   <= raster.lhbl;
            lvbl_d   <= raster.lvbl;
            hs_d     <= raster.hs;
            vs_d     <= raster.vs;
            lhbl_dly <= lhbl_d;
            lvbl_dly <= lvbl_d;
            hs       <= hs_d;
            vs       <= vs_d;
            // Black outside the active area
            if (lhbl_d && lvbl_d) begin
                rgb <= pal_mem[pal_addr];
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

/* hw/tile_layer.sv */
// Fetch must end before the next line_start (ROM answers within 8 clk); bank choice relies on an even V_TOTAL
`timescale 1ns/1ps
`include "video_consts.svh"

module tile_layer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pxl_cen,
    input  video_gfx_pkg::cpu_bus_t     cpu,
    input  video_timing_pkg::raster_t   raster,
    output logic                        rom_valid,
    output video_gfx_pkg::rom_addr_t    rom_addr,
    input  logic                        rom_ready,
    input  video_gfx_pkg::rom_row_t     rom_data,
    input  logic                        rom_ok,
    output video_gfx_pkg::pixel_t       pxl
);

    video_gfx_pkg::tile_code_t   map_mem [0:`MAP_COLS*`MAP_ROWS-1];
    video_gfx_pkg::pixel_t       lbuf    [0:1][0:`LBUF_LEN-1];

    video_timing_pkg::hcount_t   scroll_x;
    video_timing_pkg::vcount_t   scroll_y;
    video_timing_pkg::hcount_t   sx;
    video_timing_pkg::vcount_t   sy;

    video_gfx_pkg::fetch_state_t state;
    logic [3:0]                  tile_idx;
    video_timing_pkg::vcount_t   fetch_v;
    logic                        wr_bank;
    video_gfx_pkg::rom_row_t     row_q;

    logic                        fetch_go;
    video_timing_pkg::vcount_t   ry;
    logic [3:0]                  map_col;
    logic [6:0]                  map_idx;
    video_timing_pkg::hcount_t   rd_idx;

    assign fetch_go = pxl_cen && raster.line_start;
    // Map row and column for the tile being fetched, wrapping in both directions
    assign ry       = fetch_v + sy;
    assign map_col  = sx[6:3] + tile_idx;
    assign map_idx  = {ry[5:3], map_col};
    // Fine scroll shifts the read point into the extra tile
    assign rd_idx   = raster.h + video_timing_pkg::hcount_t'(sx[2:0]);

    always_ff @(posedge clk) begin
        if (cpu.we && !cpu.addr[7]) begin
            map_mem[cpu.addr[6:0]] <= cpu.data;
        end
    end

    // CPU scroll registers and the copies used for a whole frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scroll_x <= '0;
            scroll_y <= '0;
            sx       <= '0;
            sy       <= '0;
        end else begin
            if (cpu.we && cpu.addr == 8'(`SCROLL_X_ADDR)) begin
                scroll_x <= cpu.data[6:0];
            end
            if (cpu.we && cpu.addr == 8'(`SCROLL_Y_ADDR)) begin
                scroll_y <= cpu.data[5:0];
            end
            if (fetch_go && raster.v == video_timing_pkg::vcount_t'(`V_TOTAL - 1)) begin
                sx <= scroll_x;
                sy <= scroll_y;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= video_gfx_pkg::IDLE;
            tile_idx  <= '0;
            fetch_v   <= '0;
            wr_bank   <= 1'b0;
            rom_valid <= 1'b0;
            rom_addr  <= '0;
        end else begin
            case (state)
                video_gfx_pkg::IDLE: begin
                    if (fetch_go) begin
                        tile_idx <= '0;
                        // Next line goes to the bank not shown now
                        wr_bank  <= ~raster.v[0];
                        if (raster.v == video_timing_pkg::vcount_t'(`V_TOTAL - 1)) begin
                            fetch_v <= '0;
                        end else begin
                            fetch_v <= raster.v + 6'd1;
                        end
                        state <= video_gfx_pkg::READ_MAP;
                    end
                end
                video_gfx_pkg::READ_MAP: begin
                    rom_addr  <= {map_mem[map_idx], ry[2:0]};
                    rom_valid <= 1'b1;
                    state     <= video_gfx_pkg::REQ;
                end
                video_gfx_pkg::REQ: begin
                    if (rom_ready) begin
                        rom_valid <= 1'b0;
                        state     <= video_gfx_pkg::WAIT;
                    end
                end
                video_gfx_pkg::WAIT: begin
                    if (rom_ok) begin
                        state <= video_gfx_pkg::WRITE;
                    end
                end
                video_gfx_pkg::WRITE: begin
                    if (tile_idx == 4'(`FETCH_TILES - 1)) begin
                        state <= video_gfx_pkg::IDLE;
                    end else begin
                        tile_idx <= tile_idx + 4'd1;
                        state    <= video_gfx_pkg::READ_MAP;
                    end
                end
                default: state <= video_gfx_pkg::IDLE;
            endcase
        end
    end

    // ROM row capture and the eight nibbles of one tile per write
    always_ff @(posedge clk) begin
        if (state == video_gfx_pkg::WAIT && rom_ok) begin
            row_q <= rom_data;
        end
        if (state == video_gfx_pkg::WRITE) begin
            for (int k = 0; k < 8; k++) begin
                lbuf[wr_bank][{tile_idx, 3'(k)}] <= row_q[4*k +: 4];
            end
        end
    end

    // Bank on display follows the line parity
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (rd_idx < video_timing_pkg::hcount_t'(`LBUF_LEN)) begin
                pxl <= lbuf[raster.v[0]][rd_idx];
            end else begin
                pxl <= '0;
            end
        end
    end

    a_rom_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_valid && !rom_ready |=> rom_valid && $stable(rom_addr)
    ) else $error("ROM request dropped or changed under back-pressure");

    a_rom_ok_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_ok |-> state != video_gfx_pkg::IDLE
    ) else $error("ROM answer with no request outstanding");

    // Unfinished fetch leaves stale pixels in the next line
    a_fetch_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_go |-> state == video_gfx_pkg::IDLE
    ) else $error("line fetch still running at line start");

endmodule

/* hw/video_timer.sv */
// Raster is registered and changes only on pxl_cen; after reset the counters sit on the last pixel of the frame
`timescale 1ns/1ps
`include "video_consts.svh"

module video_timer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       pxl_cen,
    output video_timing_pkg::raster_t  raster
);

    video_timing_pkg::hcount_t h_nxt;
    video_timing_pkg::vcount_t v_nxt;

    // Next raster position with wrap at the end of line and frame
    always_comb begin
        h_nxt = raster.h + 7'd1;
        v_nxt = raster.v;
        if (raster.h == video_timing_pkg::hcount_t'(`H_TOTAL - 1)) begin
            h_nxt = '0;
            if (raster.v == video_timing_pkg::vcount_t'(`V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = raster.v + 6'd1;
            end
        end
    end

    // Flags are decoded from the next position so they line up with h and v
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raster.h          <= video_timing_pkg::hcount_t'(`H_TOTAL - 1);
            raster.v          <= video_timing_pkg::vcount_t'(`V_TOTAL - 1);
            raster.lhbl       <= 1'b0;
            raster.lvbl       <= 1'b0;
            raster.hs         <= 1'b0;
            raster.vs         <= 1'b0;
            raster.line_start <= 1'b0;
        end else if (pxl_cen) begin
            raster.h    <= h_nxt;
            raster.v    <= v_nxt;
            raster.lhbl <= h_nxt < video_timing_pkg::hcount_t'(`H_VISIBLE);
            raster.lvbl <= v_nxt < video_timing_pkg::vcount_t'(`V_VISIBLE);
            raster.hs   <= (h_nxt >= video_timing_pkg::hcount_t'(`H_SYNC_START)) &&
                           (h_nxt <  video_timing_pkg::hcount_t'(`H_SYNC_END));
            raster.vs   <= (v_nxt >= video_timing_pkg::vcount_t'(`V_SYNC_START)) &&
                           (v_nxt <  video_timing_pkg::vcount_t'(`V_SYNC_END));
            raster.line_start <= h_nxt == '0;
        end
    end

    // Column never leaves the line
    a_h_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        raster.h < video_timing_pkg::hcount_t'(`H_TOTAL)
    ) else $error("horizontal counter out of range");

endmodule

/* hw/video_gfx_pkg.sv */
// Graphics ROM rows are 8 pixels of 4 bits with pixel 0 in the lowest nibble
package video_gfx_pkg;

    // Colour index out of the tile layer
    typedef logic [3:0] pixel_t;

    // Tile code held in the map RAM
    typedef logic [7:0] tile_code_t;

    // Tile code times 8 plus the pixel row
    typedef logic [10:0] rom_addr_t;

    // One tile row from the graphics ROM
    typedef logic [31:0] rom_row_t;

    // CPU write port, one cycle per write
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic       we;
    } cpu_bus_t;

    // 12-bit palette colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Palette entry, bank bit on top of the pixel
    typedef logic [4:0] pal_addr_t;

    // Tile row fetch engine
    typedef enum logic [2:0] {
        IDLE,
        READ_MAP,
        REQ,
        WAIT,
        WRITE
    } fetch_state_t;

endpackage

/* hw/video_timing_pkg.sv */
// Counter widths fit the scaled raster only, so H_TOTAL stays at or below 128 and V_TOTAL at or below 64
package video_timing_pkg;

    // Pixel column within a line
    typedef logic [6:0] hcount_t;

    // Line number within a frame
    typedef logic [5:0] vcount_t;

    // Registered raster position and decoded flags
    // lhbl and lvbl are high in the active region
    typedef struct packed {
        hcount_t h;
        vcount_t v;
        logic    lhbl;
        logic    lvbl;
        logic    hs;
        logic    vs;
        // High for the whole of pixel 0
        logic    line_start;
    } raster_t;

endpackage

/* hw/video_consts.svh */
// Scaled raster values; V_TOTAL must be even and FETCH_TILES*8 must not exceed LBUF_LEN
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Horizontal geometry in pixels
`define H_TOTAL        96
`define H_VISIBLE      64
`define H_SYNC_START   72
`define H_SYNC_END     80

// Vertical geometry in lines
`define V_TOTAL        40
`define V_VISIBLE      32
`define V_SYNC_START   34
`define V_SYNC_END     36

// Tile map size in tiles
`define MAP_COLS       16
`define MAP_ROWS       8

// Visible tiles plus one for fine scroll
`define FETCH_TILES    9

// One line buffer bank, in pixels
`define LBUF_LEN       72

// CPU addresses above the map area
`define SCROLL_X_ADDR  128
`define SCROLL_Y_ADDR  129

`endif
